// File: vlog.f
+incdir+verification
design/serial_pkg.sv
design/regmap_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/bridge_ctrl.sv
design/probe_regs.sv
design/debug_bridge.sv
verification/debug_bridge_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = debug_bridge_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/bridge_tasks.svh
// uppercase hex as the protocol expects
function automatic byte_t hex_digit(input logic [3:0] n);
    string digits;
    digits = "0123456789ABCDEF";
    return digits.getc(int'(n));
endfunction

// D then four digits msb first then CR and LF
function automatic byte_t expected_resp_byte(input word_t w, input int idx);
    word_t sh;
    case (idx)
        0: return char_data;
        5: return char_cr;
        6: return char_lf;
        default: begin
            sh = w >> (16 - 4 * idx);
            return hex_digit(sh[3:0]);
        end
    endcase
endfunction

task automatic send_hex16(input word_t w);
    word_t sh;
    int i;
    for (i = 3; i >= 0; i--) begin
        sh = w >> (4 * i);
        send_byte(hex_digit(sh[3:0]));
    end
endtask

task automatic send_read(input addr_t a, input byte_t term);
    send_byte(char_read);
    send_hex16(word_t'(a));
    send_byte(term);
endtask

// access lands a few cycles after the terminator and the strobe copy one cycle later
task automatic wait_update();
    repeat (4) @(negedge clk);
endtask

task automatic write_reg(input addr_t a, input word_t d);
    send_byte(char_write);
    send_hex16(word_t'(a));
    send_hex16(d);
    send_byte(char_cr);
    wait_update();
endtask

task automatic read_expect(input addr_t a, input word_t exp, input byte_t term);
    byte_t b;
    bit got;
    int i;
    send_read(a, term);
    for (i = 0; i < resp_len; i++) begin
        recv_byte(resp_timeout, b, got);
        if (!got) begin
            response_errors++;
            $display("no response byte %0d for read of address %h", i, a);
            return;
        end
        if (b !== expected_resp_byte(exp, i)) begin
            value_errors++;
            $display("error: tx_o byte %0d of read %h is %h, expected %h",
                     i, a, b, expected_resp_byte(exp, i));
        end
    end
endtask

task automatic check_outputs(input probe_t e0, input probe_t e1);
    if (probe_out0_o !== e0) begin
        value_errors++;
        $display("error: probe_out0_o is %h, expected %h", probe_out0_o, e0);
    end
    if (probe_out1_o !== e1) begin
        value_errors++;
        $display("error: probe_out1_o is %h, expected %h", probe_out1_o, e1);
    end
endtask

task automatic check_quiet(input string what);
    byte_t b;
    bit got;
    recv_byte(quiet_cycles, b, got);
    if (got) begin
        response_errors++;
        $display("unexpected byte %h on tx_o after %s", b, what);
    end
endtask

task automatic test_output_write();
    int i;
    for (i = 0; i < 4; i++) begin
        out_model[i] = word_t'($urandom);
        write_reg(addr_t'(addr_out_base + i), out_model[i]);
    end
    check_outputs('0, '0);
    write_reg(addr_t'(addr_strobe), 16'h0001);
    check_outputs({out_model[1], out_model[0]}, {out_model[3], out_model[2]});
    // input halves are read only
    for (i = 0; i < 4; i++) begin
        write_reg(addr_t'(addr_in_base + i), word_t'($urandom));
    end
    check_outputs({out_model[1], out_model[0]}, {out_model[3], out_model[2]});
endtask

task automatic test_input_read();
    int i;
    in_model[0] = probe_t'($urandom);
    in_model[1] = probe_t'($urandom);
    @(negedge clk);
    probe_in0_i = in_model[0];
    probe_in1_i = in_model[1];
    wait_update();
    for (i = 0; i < 4; i++) begin
        read_expect(addr_t'(addr_in_base + i), in_model[i / 2][16 * (i % 2) +: 16], char_cr);
    end
    write_reg(addr_t'(addr_strobe), 16'h0000);
    @(negedge clk);
    probe_in0_i = probe_t'($urandom);
    probe_in1_i = probe_t'($urandom);
    wait_update();
    // snapshot frozen with strobe clear
    for (i = 0; i < 4; i++) begin
        read_expect(addr_t'(addr_in_base + i), in_model[i / 2][16 * (i % 2) +: 16], char_lf);
    end
endtask

task automatic test_readback();
    int i;
    for (i = 0; i < 4; i++) begin
        read_expect(addr_t'(addr_out_base + i), out_model[i], char_cr);
    end
    read_expect(addr_t'(addr_strobe), 16'h0000, char_cr);
    write_reg(addr_t'(addr_strobe), 16'h0001);
    read_expect(addr_t'(addr_strobe), 16'h0001, char_lf);
endtask

task automatic test_unmapped();
    read_expect(addr_t'(addr_last + 1), 16'h0000, char_cr);
    read_expect(16'h1234, 16'h0000, char_lf);
    read_expect(16'hFFFF, 16'h0000, char_cr);
endtask

task automatic test_malformed();
    send_text("R00a1");
    send_byte(char_cr);
    check_quiet("lowercase hex digit");
    send_text("R0G01");
    send_byte(char_cr);
    check_quiet("non-hex byte");
    send_text("R00011");
    send_byte(char_cr);
    check_quiet("missing terminator");
    send_text("W0005BEEF;");
    check_quiet("wrong terminator");
    send_text("W0006123");
    send_byte(char_lf);
    check_quiet("short write");
    check_outputs({out_model[1], out_model[0]}, {out_model[3], out_model[2]});
    read_expect(addr_t'(addr_out_base), out_model[0], char_cr);
endtask

// File: verification/debug_bridge_tb.sv
module debug_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import serial_pkg::*;
    import regmap_pkg::*;

    localparam int half_period = 20;
    // longest wait for the next response byte across the handshake gap
    localparam int resp_timeout = 3 * clocks_per_baud;
    localparam int quiet_cycles = 20 * clocks_per_baud;
    localparam int frame_cycles = 10 * clocks_per_baud;
    // byte totals of the directed tests
    localparam int cmd_bytes = 256;
    localparam int resp_bytes = 126;
    localparam int watchdog_cycles = (cmd_bytes + resp_bytes) * frame_cycles * 5 / 4
                                     + 6 * quiet_cycles;

    logic clk;
    logic reset_i;
    logic rx_i;
    logic tx_o;
    probe_t probe_in0_i;
    probe_t probe_in1_i;
    probe_t probe_out0_o;
    probe_t probe_out1_o;

    int value_errors;
    int response_errors;
    // what the register bank should hold
    word_t out_model [4];
    probe_t in_model [num_in_probes];

    debug_bridge debug_bridge_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .rx_i         (rx_i),
        .tx_o         (tx_o),
        .probe_in0_i  (probe_in0_i),
        .probe_in1_i  (probe_in1_i),
        .probe_out0_o (probe_out0_o),
        .probe_out1_o (probe_out1_o)
    );

    always #half_period clk = ~clk;

    // 8N1 frame on rx_i with lsb first
    task automatic send_byte(input byte_t b);
        int i;
        @(negedge clk);
        rx_i = 1'b0;
        repeat (clocks_per_baud) @(negedge clk);
        for (i = 0; i < byte_w; i++) begin
            rx_i = b[i];
            repeat (clocks_per_baud) @(negedge clk);
        end
        rx_i = 1'b1;
        repeat (clocks_per_baud) @(negedge clk);
    endtask

    task automatic send_text(input string s);
        int i;
        for (i = 0; i < s.len(); i++) begin
            send_byte(s.getc(i));
        end
    endtask

    // waits up to wait_cycles for a start bit and then samples mid-bit
    task automatic recv_byte(input int wait_cycles, output byte_t b, output bit got);
        int n;
        int i;
        got = 1'b0;
        b = '0;
        n = 0;
        while ((n < wait_cycles) && !got) begin
            @(negedge clk);
            if (tx_o == 1'b0) begin
                got = 1'b1;
            end
            n++;
        end
        if (got) begin
            repeat (clocks_per_baud / 2) @(negedge clk);
            if (tx_o !== 1'b0) begin
                response_errors++;
                $display("start bit on tx_o ended before the middle of the bit");
            end
            for (i = 0; i < byte_w; i++) begin
                repeat (clocks_per_baud) @(negedge clk);
                b[i] = tx_o;
            end
            repeat (clocks_per_baud) @(negedge clk);
            if (tx_o !== 1'b1) begin
                response_errors++;
                $display("stop bit missing on tx_o after byte %h", b);
            end
        end
    endtask

    `include "bridge_tasks.svh"

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        rx_i = 1'b1;
        probe_in0_i = '0;
        probe_in1_i = '0;
        value_errors = 0;
        response_errors = 0;
        void'($urandom(39));
        repeat (2) @(negedge clk);
        reset_i = 1'b0;
        repeat (2) @(negedge clk);
        test_output_write();
        test_input_read();
        test_readback();
        test_unmapped();
        test_malformed();
        $display("%0d value errors, %0d response errors", value_errors, response_errors);
        if ((value_errors + response_errors) == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not complete", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: design/debug_bridge.sv
module debug_bridge (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               rx_i,
    output logic               tx_o,
    input  regmap_pkg::probe_t probe_in0_i,
    input  regmap_pkg::probe_t probe_in1_i,
    output regmap_pkg::probe_t probe_out0_o,
    output regmap_pkg::probe_t probe_out1_o
);
    import serial_pkg::*;
    import regmap_pkg::*;

    // serial receive side
    byte_t rx_data;
    logic rx_valid;

    // register bus
    addr_t reg_addr;
    word_t reg_wdata;
    logic reg_write;
    logic reg_valid;
    word_t rd_data;
    logic rd_valid;

    // transmit handshake
    byte_t tx_data;
    logic tx_req;
    logic tx_ack;

    uart_rx uart_rx_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .rx_i       (rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    bridge_ctrl bridge_ctrl_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .reg_addr_o  (reg_addr),
        .reg_wdata_o (reg_wdata),
        .reg_write_o (reg_write),
        .reg_valid_o (reg_valid),
        .rd_data_i   (rd_data),
        .rd_valid_i  (rd_valid),
        .tx_data_o   (tx_data),
        .tx_req_o    (tx_req),
        .tx_ack_i    (tx_ack)
    );

    probe_regs probe_regs_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_write_i  (reg_write),
        .reg_valid_i  (reg_valid),
        .rd_data_o    (rd_data),
        .rd_valid_o   (rd_valid),
        .probe_in0_i  (probe_in0_i),
        .probe_in1_i  (probe_in1_i),
        .probe_out0_o (probe_out0_o),
        .probe_out1_o (probe_out1_o)
    );

    uart_tx uart_tx_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .tx_data_i (tx_data),
        .tx_req_i  (tx_req),
        .tx_ack_o  (tx_ack),
        .tx_o      (tx_o)
    );

endmodule

// File: design/probe_regs.sv
module probe_regs (
    input  logic               clk,
    input  logic               reset_i,
    input  regmap_pkg::addr_t  reg_addr_i,
    input  regmap_pkg::word_t  reg_wdata_i,
    input  logic               reg_write_i,
    input  logic               reg_valid_i,
    output regmap_pkg::word_t  rd_data_o,
    output logic               rd_valid_o,
    input  regmap_pkg::probe_t probe_in0_i,
    input  regmap_pkg::probe_t probe_in1_i,
    output regmap_pkg::probe_t probe_out0_o,
    output regmap_pkg::probe_t probe_out1_o
);
    import regmap_pkg::*;

    localparam int in_idx_w = $clog2(num_in_probes);
    localparam int out_idx_w = $clog2(num_out_probes);

    probe_t probe_in [num_in_probes];
    probe_t in_snap_q [num_in_probes];
    probe_t out_buf_q [num_out_probes];
    probe_t out_q [num_out_probes];
    logic strobe_q;

    addr_t in_off;
    addr_t out_off;
    logic in_hit;
    logic out_hit;
    logic [in_idx_w-1:0] in_idx;
    logic [out_idx_w-1:0] out_idx;
    word_t rd_word;

    assign probe_in[0] = probe_in0_i;
    assign probe_in[1] = probe_in1_i;
    assign probe_out0_o = out_q[0];
    assign probe_out1_o = out_q[1];

    // address decode, bit 0 of the offset picks the half
    assign in_off = reg_addr_i - addr_t'(addr_in_base);
    assign out_off = reg_addr_i - addr_t'(addr_out_base);
    assign in_hit = (reg_addr_i >= addr_t'(addr_in_base)) &&
                    (in_off < addr_t'(2 * num_in_probes));
    assign out_hit = (reg_addr_i >= addr_t'(addr_out_base)) &&
                     (reg_addr_i <= addr_t'(addr_last));
    assign in_idx = in_off[in_idx_w:1];
    assign out_idx = out_off[out_idx_w:1];

    // unmapped reads return zero
    always_comb begin
        rd_word = '0;
        if (reg_addr_i == addr_t'(addr_strobe)) begin
            rd_word = {{(data_w-1){1'b0}}, strobe_q};
        end else if (in_hit) begin
            rd_word = in_off[0] ? in_snap_q[in_idx][probe_w-1:data_w] :
                                  in_snap_q[in_idx][data_w-1:0];
        end else if (out_hit) begin
            rd_word = out_off[0] ? out_buf_q[out_idx][probe_w-1:data_w] :
                                   out_buf_q[out_idx][data_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= reg_valid_i && !reg_write_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_valid_i && !reg_write_i) begin
            rd_data_o <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            strobe_q <= 1'b0;
            in_snap_q <= '{default: '0};
            out_buf_q <= '{default: '0};
            out_q <= '{default: '0};
        end else begin
            // writes to read-only or unmapped addresses fall through
            if (reg_valid_i && reg_write_i) begin
                if (reg_addr_i == addr_t'(addr_strobe)) begin
                    strobe_q <= reg_wdata_i[0];
                end else if (out_hit) begin
                    if (out_off[0]) begin
                        out_buf_q[out_idx][probe_w-1:data_w] <= reg_wdata_i;
                    end else begin
                        out_buf_q[out_idx][data_w-1:0] <= reg_wdata_i;
                    end
                end
            end
            // probes track the buffers every clock while strobe is set
            if (strobe_q) begin
                in_snap_q <= probe_in;
                out_q <= out_buf_q;
            end
        end
    end

endmodule

// File: design/bridge_ctrl.sv
module bridge_ctrl (
    input  logic              clk,
    input  logic              reset_i,
    input  serial_pkg::byte_t rx_data_i,
    input  logic              rx_valid_i,
    output regmap_pkg::addr_t reg_addr_o,
    output regmap_pkg::word_t reg_wdata_o,
    output logic              reg_write_o,
    output logic              reg_valid_o,
    input  regmap_pkg::word_t rd_data_i,
    input  logic              rd_valid_i,
    output serial_pkg::byte_t tx_data_o,
    output logic              tx_req_o,
    input  logic              tx_ack_i
);
    import serial_pkg::*;
    import regmap_pkg::*;

    typedef enum logic [1:0] {
        parse_idle,
        parse_read,
        parse_write
    } parse_state_t;

    typedef enum logic [1:0] {
        resp_idle,
        resp_req,
        resp_wait
    } resp_state_t;

    parse_state_t parse_q;
    logic [3:0] digit_cnt_q;
    // address nibbles first, then data nibbles for a write
    logic [addr_w+data_w-1:0] field_q;
    logic [3:0] digits_needed;
    logic have_digits;
    logic is_term;

    resp_state_t resp_q;
    logic [2:0] resp_idx_q;
    word_t resp_word_q;

    assign digits_needed = (parse_q == parse_read) ? 4'(addr_w / 4) : 4'((addr_w + data_w) / 4);
    assign have_digits = (digit_cnt_q == digits_needed);
    assign is_term = (rx_data_i == char_cr) || (rx_data_i == char_lf);

    // command parser
    always_ff @(posedge clk) begin
        if (reset_i) begin
            parse_q <= parse_idle;
            digit_cnt_q <= '0;
            reg_valid_o <= 1'b0;
        end else begin
            reg_valid_o <= 1'b0;
            if (rx_valid_i) begin
                case (parse_q)
                    parse_idle: begin
                        digit_cnt_q <= '0;
                        if (rx_data_i == char_read) begin
                            parse_q <= parse_read;
                        end else if (rx_data_i == char_write) begin
                            parse_q <= parse_write;
                        end
                    end
                    default: begin
                        if (!have_digits) begin
                            if (is_hex_char(rx_data_i)) begin
                                digit_cnt_q <= digit_cnt_q + 4'd1;
                            end else begin
                                parse_q <= parse_idle;
                            end
                        end else begin
                            // last byte must be the terminator
                            parse_q <= parse_idle;
                            reg_valid_o <= is_term;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid_i && (parse_q != parse_idle)) begin
            if (!have_digits) begin
                field_q <= {field_q[addr_w+data_w-5:0], hex_to_nibble(rx_data_i)};
            end else begin
                reg_write_o <= (parse_q == parse_write);
                reg_wdata_o <= field_q[data_w-1:0];
                if (parse_q == parse_read) begin
                    reg_addr_o <= field_q[addr_w-1:0];
                end else begin
                    reg_addr_o <= field_q[addr_w+data_w-1:data_w];
                end
            end
        end
    end

    // response sequencer, one handshake per byte
    always_ff @(posedge clk) begin
        if (reset_i) begin
            resp_q <= resp_idle;
            resp_idx_q <= '0;
            tx_req_o <= 1'b0;
        end else begin
            case (resp_q)
                resp_idle: begin
                    // reads finishing mid-response are dropped
                    if (rd_valid_i) begin
                        resp_q <= resp_req;
                        resp_idx_q <= '0;
                        tx_req_o <= 1'b1;
                    end
                end
                resp_req: begin
                    if (tx_ack_i) begin
                        tx_req_o <= 1'b0;
                        resp_q <= resp_wait;
                    end
                end
                default: begin
                    // ack low means the frame is fully out
                    if (!tx_ack_i) begin
                        if (resp_idx_q == 3'(resp_len - 1)) begin
                            resp_q <= resp_idle;
                        end else begin
                            resp_idx_q <= resp_idx_q + 3'd1;
                            tx_req_o <= 1'b1;
                            resp_q <= resp_req;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((resp_q == resp_idle) && rd_valid_i) begin
            resp_word_q <= rd_data_i;
        end
    end

    always_comb begin
        case (resp_idx_q)
            3'd0: tx_data_o = char_data;
            3'd1: tx_data_o = nibble_to_hex(resp_word_q[15:12]);
            3'd2: tx_data_o = nibble_to_hex(resp_word_q[11:8]);
            3'd3: tx_data_o = nibble_to_hex(resp_word_q[7:4]);
            3'd4: tx_data_o = nibble_to_hex(resp_word_q[3:0]);
            3'd5: tx_data_o = char_cr;
            default: tx_data_o = char_lf;
        endcase
    end

    a_single_access: assert property (@(posedge clk) disable iff (reset_i)
        reg_valid_o |=> !reg_valid_o);

    a_tx_data_stable: assert property (@(posedge clk) disable iff (reset_i)
        $past(tx_req_o) && tx_req_o |-> $stable(tx_data_o));

endmodule

// File: design/uart_tx.sv
module uart_tx (
    input  logic              clk,
    input  logic              reset_i,
    input  serial_pkg::byte_t tx_data_i,
    input  logic              tx_req_i,
    output logic              tx_ack_o,
    output logic              tx_o
);
    import serial_pkg::*;

    localparam int baud_w = $clog2(clocks_per_baud);
    localparam logic [3:0] last_bit = 4'd9;

    logic [baud_w-1:0] baud_cnt_q;
    logic [3:0] bit_cnt_q;
    // data bits followed by the stop bit
    logic [byte_w:0] frame_q;
    logic busy_q;
    logic accept;
    logic bit_end;

    // new request only seen once the previous ack has dropped
    assign accept = !tx_ack_o && tx_req_i;
    assign bit_end = busy_q && (baud_cnt_q == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_o <= 1'b1;
            tx_ack_o <= 1'b0;
            busy_q <= 1'b0;
            bit_cnt_q <= '0;
            baud_cnt_q <= '0;
        end else if (!tx_ack_o) begin
            if (tx_req_i) begin
                // start bit goes out right away
                tx_ack_o <= 1'b1;
                busy_q <= 1'b1;
                tx_o <= 1'b0;
                bit_cnt_q <= '0;
                baud_cnt_q <= baud_w'(clocks_per_baud - 1);
            end
        end else if (busy_q) begin
            if (bit_end) begin
                baud_cnt_q <= baud_w'(clocks_per_baud - 1);
                if (bit_cnt_q == last_bit) begin
                    busy_q <= 1'b0;
                end else begin
                    tx_o <= frame_q[0];
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                end
            end else begin
                baud_cnt_q <= baud_cnt_q - 1'b1;
            end
        end else if (!tx_req_i) begin
            // stop bit done and request released
            tx_ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            frame_q <= {1'b1, tx_data_i};
        end else if (bit_end && (bit_cnt_q != last_bit)) begin
            frame_q <= frame_q >> 1;
        end
    end

    a_ack_held: assert property (@(posedge clk) disable iff (reset_i)
        tx_ack_o && tx_req_i |=> tx_ack_o);

endmodule

// File: design/uart_rx.sv
module uart_rx (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              rx_i,
    output serial_pkg::byte_t rx_data_o,
    output logic              rx_valid_o
);
    import serial_pkg::*;

    // wide enough for the 1.5 bit delay after the start edge
    localparam int cnt_w = $clog2(clocks_per_baud * 2);
    localparam logic [3:0] state_idle = 4'd0;
    localparam logic [3:0] state_first = 4'd1;
    localparam logic [3:0] state_stop = 4'd9;

    logic rx_meta_q;
    logic rx_sync_q;
    logic [3:0] bit_state_q;
    logic [cnt_w-1:0] baud_cnt_q;
    byte_t shift_q;
    logic baud_done;

    assign baud_done = (baud_cnt_q == '0);
    assign rx_data_o = shift_q;

    // two flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bit_state_q <= state_idle;
            baud_cnt_q <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (bit_state_q == state_idle) begin
                // start edge, skip to the middle of data bit 0
                if (!rx_sync_q) begin
                    bit_state_q <= state_first;
                    baud_cnt_q <= cnt_w'(clocks_per_baud + clocks_per_baud / 2 - 1);
                end
            end else if (baud_done) begin
                if (bit_state_q == state_stop) begin
                    bit_state_q <= state_idle;
                    rx_valid_o <= 1'b1;
                end else begin
                    bit_state_q <= bit_state_q + 4'd1;
                    baud_cnt_q <= cnt_w'(clocks_per_baud - 1);
                end
            end else begin
                baud_cnt_q <= baud_cnt_q - 1'b1;
            end
        end
    end

    // data arrives lsb first
    always_ff @(posedge clk) begin
        if (baud_done && (bit_state_q >= state_first) && (bit_state_q < state_stop)) begin
            shift_q <= {rx_sync_q, shift_q[byte_w-1:1]};
        end
    end

    a_state_in_range: assert property (@(posedge clk) disable iff (reset_i)
        bit_state_q <= state_stop);

endmodule

// File: design/regmap_pkg.sv
package regmap_pkg;

    // bus widths
    localparam int addr_w = 16;
    localparam int data_w = 16;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] word_t;

    localparam int probe_w = 32;

    typedef logic [probe_w-1:0] probe_t;

    localparam int num_in_probes = 2;
    localparam int num_out_probes = 2;

    // register map, each probe takes two addresses with the low half first
    localparam int addr_strobe = 0;

    // input snapshots are read only
    localparam int addr_in_base = 1;

    // output buffers are read/write
    localparam int addr_out_base = 5;
    localparam int addr_last = 8;

endpackage

// File: design/serial_pkg.sv
package serial_pkg;

    // bit period in clk cycles, kept short so simulation runs quickly
    localparam int clocks_per_baud = 8;
    localparam int byte_w = 8;

    typedef logic [byte_w-1:0] byte_t;

    // protocol characters
    localparam byte_t char_read = 8'h52;
    localparam byte_t char_write = 8'h57;
    localparam byte_t char_data = 8'h44;
    localparam byte_t char_cr = 8'h0D;
    localparam byte_t char_lf = 8'h0A;

    // D, four hex digits, CR, LF
    localparam int resp_len = 7;

    // only 0-9 and uppercase A-F count as hex
    function automatic logic is_hex_char(input byte_t c);
        return ((c >= 8'h30) && (c <= 8'h39)) || ((c >= 8'h41) && (c <= 8'h46));
    endfunction

    function automatic logic [3:0] hex_to_nibble(input byte_t c);
        byte_t v;
        if (c <= 8'h39) begin
            v = c - 8'h30;
        end else begin
            v = c - 8'h37;
        end
        return v[3:0];
    endfunction

    function automatic byte_t nibble_to_hex(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + byte_t'(n);
        end
        return 8'h37 + byte_t'(n);
    endfunction

endpackage
